// File: Bender.yml
package:
  name: exec_stage

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/exec_pkg.sv
  - rtl/mem_if.sv
  - rtl/alu.sv
  - rtl/exec_unit.sv
  - rtl/data_ram.sv
  - rtl/exec_top.sv
  - target: simulation
    files:
      - dv/exec_tb.sv

// File: all.f
rtl/rv_isa_pkg.sv
rtl/exec_pkg.sv
rtl/mem_if.sv
rtl/alu.sv
rtl/exec_unit.sv
rtl/data_ram.sv
rtl/exec_top.sv
dv/exec_tb.sv

// File: dv/exec_tb.sv
`timescale 1ns/1ps

module exec_tb
    import rv_isa_pkg::*, exec_pkg::*;
();

    logic               clk;
    logic               rst_n;
    logic               en;
    logic [OP_BITS-1:0] op;
    logic [F7_BITS-1:0] funct7;
    logic [F3_BITS-1:0] funct3;
    logic [XLEN-1:0]    pc_in;
    logic [XLEN-1:0]    rs1;
    logic [XLEN-1:0]    rs2;
    logic [XLEN-1:0]    imm;
    logic [XLEN-1:0]    pc_out;
    logic [XLEN-1:0]    val_out;
    logic               flush_pipeline;
    logic               ready;

    logic [XLEN-1:0]    exp_pc;
    logic [XLEN-1:0]    exp_val;
    logic               exp_flush;
    logic               chk_val;     // Stores and branches leave val_out unchecked.
    logic [7:0]         ram_model [RAM_BYTES];
    integer             seed;

    exec_top exec_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .op             (op),
        .funct7         (funct7),
        .funct3         (funct3),
        .pc_in          (pc_in),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .pc_out         (pc_out),
        .val_out        (val_out),
        .flush_pipeline (flush_pipeline),
        .ready          (ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Failure reporting.
    ////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_mismatch(input string sig, input logic [XLEN-1:0] expv,
                                   input logic [XLEN-1:0] actv);
        $display("MISMATCH at %0t: %s expected %h actual %h", $time, sig, expv, actv);
        abort_run();
    endtask

    ////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////

    function automatic logic [XLEN-1:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] res;
        case (f3)
            F3_ADD:  res = alt ? a - b : a + b;
            F3_SLL:  res = a << b[4:0];
            F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  res = a ^ b;
            F3_SR: begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            F3_OR:   res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        case (f3)
            F3_EQ:   return a == b;
            F3_NE:   return a != b;
            F3_LT:   return $signed(a) < $signed(b);
            F3_GE:   return $signed(a) >= $signed(b);
            F3_LTU:  return a < b;
            F3_GEU:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] load_ref(input logic [2:0] f3,
                                                 input logic [XLEN-1:0] addr);
        logic [7:0] b0;
        logic [7:0] b1;
        logic       sx;
        b0 = ram_model[addr[RAM_ADDR_BITS-1:0]];
        b1 = ram_model[RAM_ADDR_BITS'(addr + 1)];
        sx = !f3[2]; // Zero-extend when bit 2 is set.
        case (f3[1:0])
            2'b00:   return {{24{sx & b0[7]}}, b0};
            2'b01:   return {{16{sx & b1[7]}}, b1, b0};
            default: return {ram_model[RAM_ADDR_BITS'(addr + 3)],
                             ram_model[RAM_ADDR_BITS'(addr + 2)], b1, b0};
        endcase
    endfunction

    task automatic store_model(input logic [2:0] f3, input logic [XLEN-1:0] addr,
                               input logic [XLEN-1:0] data);
        int nbytes;
        nbytes = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
        for (int i = 0; i < nbytes; i++)
            ram_model[RAM_ADDR_BITS'(addr + i)] = data[8*i +: 8]; // Little-endian.
    endtask

    task automatic predict(input logic [6:0] o, input logic [6:0] f7, input logic [2:0] f3,
                           input logic [XLEN-1:0] pc, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] im);
        logic [XLEN-1:0] ea;
        ea        = a + im;
        exp_pc    = pc + 32'd4;
        exp_val   = '0;
        exp_flush = 1'b0;
        chk_val   = 1'b1;
        case (o)
            OP_LUI:         exp_val = im;
            OP_AUIPC:       exp_val = pc + im;
            OP_INTEGER:     exp_val = alu_ref(f3, f7[5], a, b);
            OP_INTEGER_IMM: exp_val = alu_ref(f3, (f3 == F3_SR) && f7[5], a, im);
            OP_LOAD:        exp_val = load_ref(f3, ea);
            OP_JAL, OP_JALR: begin
                exp_val   = pc + 32'd4;
                exp_pc    = (o == OP_JAL) ? pc + im : ea & ~32'd1;
                exp_flush = 1'b1;
            end
            OP_STORE: begin
                chk_val = 1'b0;
                store_model(f3, ea, b);
            end
            default: begin // Branches.
                chk_val   = 1'b0;
                exp_flush = branch_taken(f3, a, b);
                if (exp_flush)
                    exp_pc = pc + im;
            end
        endcase
    endtask

    ////////////////////////////////////////
    // Output checks.
    ////////////////////////////////////////

    a_val: assert property (@(posedge clk) disable iff (!rst_n)
        (ready && en && chk_val) |-> (val_out == exp_val))
        else report_mismatch("val_out", exp_val, $sampled(val_out));

    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (ready && en) |-> (pc_out == exp_pc))
        else report_mismatch("pc_out", exp_pc, $sampled(pc_out));

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (ready && en) |-> (flush_pipeline == exp_flush))
        else report_mismatch("flush_pipeline", exp_flush, $sampled(flush_pipeline));

    ////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////

    // Called on a falling edge; returns on a falling edge with en low.
    task automatic run_instr(input logic [6:0] o, input logic [6:0] f7, input logic [2:0] f3,
                             input logic [XLEN-1:0] pc, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b, input logic [XLEN-1:0] im);
        int   edges;
        logic is_mem;
        is_mem = (o == OP_LOAD) || (o == OP_STORE);
        predict(o, f7, f3, pc, a, b, im);
        op     = o;
        funct7 = f7;
        funct3 = f3;
        pc_in  = pc;
        rs1    = a;
        rs2    = b;
        imm    = im;
        en     = 1'b1;
        @(negedge clk);
        edges = 1;
        while (!ready && edges < 4 * (RAM_WAIT + 2)) begin
            @(negedge clk);
            edges++;
        end
        if (!ready)
            report_error("ready never came for the issued instruction");
        if (is_mem) begin
            assert (edges >= RAM_WAIT + 1)
                else report_error("ready rose too early for a memory access");
        end else begin
            assert (edges == 2) else report_mismatch("ready latency", 32'd2, edges);
        end
        @(negedge clk);   // One edge with ready and en both high.
        en = 1'b0;
        @(negedge clk);
        assert (!ready) else report_error("ready stayed high after en dropped");
    endtask

    function automatic logic [XLEN-1:0] rand_imm12();
        logic [XLEN-1:0] r;
        r = next_rand();
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // Effective address is rs1 plus a random immediate.
    task automatic mem_access(input logic [6:0] o, input logic [2:0] f3,
                              input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        logic [XLEN-1:0] im;
        im = rand_imm12();
        run_instr(o, 7'h00, f3, next_rand() & ~32'd3, addr - im, data, im);
    endtask

    logic [XLEN-1:0] edge_vals [6];
    logic [2:0]      br_f3 [6];
    logic [XLEN-1:0] base;

    initial begin
        seed      = 32'hd1e3;
        rst_n     = 1'b0;
        en        = 1'b0;
        op        = '0;
        funct7    = '0;
        funct3    = '0;
        pc_in     = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        chk_val   = 1'b0;
        exp_pc    = '0;
        exp_val   = '0;
        exp_flush = 1'b0;
        edge_vals = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h0};
        br_f3     = '{F3_EQ, F3_NE, F3_LT, F3_GE, F3_LTU, F3_GEU};
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        assert (!ready) else report_error("ready is high right after reset");

        // ALU ops in register and immediate form; funct7 bit 5 gives SUB and SRA(I).
        for (int r = 0; r < 4; r++) begin
            for (int f = 0; f < 8; f++) begin
                for (int m = 0; m < 2; m++) begin
                    run_instr(OP_INTEGER, m ? 7'h20 : 7'h00, 3'(f), next_rand() & ~32'd3,
                              next_rand(), next_rand(), '0);
                    run_instr(OP_INTEGER_IMM, m ? 7'h20 : 7'h00, 3'(f), next_rand() & ~32'd3,
                              next_rand(), '0, rand_imm12());
                end
            end
        end

        for (int r = 0; r < 4; r++) begin
            run_instr(OP_LUI, 7'h00, 3'h0, next_rand(), next_rand(), '0,
                      next_rand() & 32'hfffff000);
            run_instr(OP_AUIPC, 7'h00, 3'h0, next_rand(), '0, '0, next_rand() & 32'hfffff000);
            run_instr(OP_JAL, 7'h00, 3'h0, next_rand(), '0, '0, rand_imm12());
            run_instr(OP_JALR, 7'h00, 3'h0, next_rand(), next_rand(), '0, rand_imm12());
        end

        // Branches on every pair of edge values, equal pairs included.
        edge_vals[5] = next_rand();
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                for (int f = 0; f < 6; f++)
                    run_instr(OP_BRANCH, 7'h00, br_f3[f], next_rand() & ~32'd3,
                              edge_vals[i], edge_vals[j], rand_imm12() & ~32'd1);
            end
        end

        // Word first so every later load reads written bytes.
        for (int r = 0; r < 6; r++) begin
            base = next_rand() & ~32'd3;
            mem_access(OP_STORE, 3'b010, base, next_rand());
            mem_access(OP_STORE, 3'b000, base + (next_rand() & 32'd3), next_rand());
            mem_access(OP_STORE, 3'b001, base + (next_rand() & 32'd2), next_rand());
            mem_access(OP_LOAD, 3'b000, base + (next_rand() & 32'd3), '0);
            mem_access(OP_LOAD, 3'b100, base + (next_rand() & 32'd3), '0);
            mem_access(OP_LOAD, 3'b001, base + (next_rand() & 32'd2), '0);
            mem_access(OP_LOAD, 3'b101, base + (next_rand() & 32'd2), '0);
            mem_access(OP_LOAD, 3'b010, base, '0);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu
    import rv_isa_pkg::*;
(
    input  logic [F3_BITS-1:0] funct3,
    input  logic               modifier,
    input  logic [XLEN-1:0]    in1,
    input  logic [XLEN-1:0]    in2,
    output logic [XLEN-1:0]    out
);

    logic [4:0]             shamt;
    logic signed [XLEN-1:0] sra_out;
    logic                   lt_signed;
    logic                   lt_unsigned;

    assign shamt = in2[4:0];

    // Arithmetic right shift.
    assign sra_out = $signed(in1) >>> shamt;

    assign lt_signed   = $signed(in1) < $signed(in2);
    assign lt_unsigned = in1 < in2;

    always_comb begin
        case (funct3)
            F3_ADD: begin
                if (modifier)
                    out = in1 - in2;
                else
                    out = in1 + in2;
            end
            F3_SLL:  out = in1 << shamt;
            F3_SLT:  out = {{(XLEN-1){1'b0}}, lt_signed};
            F3_SLTU: out = {{(XLEN-1){1'b0}}, lt_unsigned};
            F3_XOR:  out = in1 ^ in2;
            F3_SR: begin
                if (modifier)
                    out = sra_out;
                else
                    out = in1 >> shamt;
            end
            F3_OR:   out = in1 | in2;
            F3_AND:  out = in1 & in2;
            default: out = '0;
        endcase
    end

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    mem_if.slave mem
);

    logic [7:0]              bytes [RAM_BYTES];
    logic [RAM_CNT_BITS-1:0] wait_cnt;
    logic                    busy;     // Access done, waiting for req to drop.
    logic                    fire;
    logic [RAM_ADDR_BITS-1:0] idx0;
    logic [RAM_ADDR_BITS-1:0] idx1;
    logic [RAM_ADDR_BITS-1:0] idx2;
    logic [RAM_ADDR_BITS-1:0] idx3;

    // Addresses wrap at the memory size.
    assign idx0 = mem.addr[RAM_ADDR_BITS-1:0];
    assign idx1 = idx0 + RAM_ADDR_BITS'(1);
    assign idx2 = idx0 + RAM_ADDR_BITS'(2);
    assign idx3 = idx0 + RAM_ADDR_BITS'(3);

    assign fire      = mem.req && !busy && (wait_cnt == RAM_CNT_BITS'(RAM_WAIT));
    assign mem.ready = fire;

    ////////////////////////////////////////
    // Wait counter.
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            busy     <= 1'b0;
        end else if (fire) begin
            wait_cnt <= '0;
            busy     <= 1'b1;
        end else if (!mem.req) begin
            wait_cnt <= '0;
            busy     <= 1'b0;
        end else if (!busy) begin
            wait_cnt <= wait_cnt + RAM_CNT_BITS'(1);
        end
    end

    ////////////////////////////////////////
    // Storage, little-endian.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fire && mem.we) begin
            bytes[idx0] <= mem.wdata[7:0];
            if (mem.width != MEM_ACC_8)
                bytes[idx1] <= mem.wdata[15:8];
            if (mem.width == MEM_ACC_32) begin
                bytes[idx2] <= mem.wdata[23:16];
                bytes[idx3] <= mem.wdata[31:24];
            end
        end
    end

    always_comb begin
        case (mem.width)
            MEM_ACC_8:  mem.rdata = {24'h0, bytes[idx0]};
            MEM_ACC_16: mem.rdata = {16'h0, bytes[idx1], bytes[idx0]};
            default:    mem.rdata = {bytes[idx3], bytes[idx2], bytes[idx1], bytes[idx0]};
        endcase
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem.req |-> (mem.width == MEM_ACC_8)
                 || (mem.width == MEM_ACC_16 && !mem.addr[0])
                 || (mem.width == MEM_ACC_32 && mem.addr[1:0] == 2'b00));

endmodule

// File: rtl/exec_pkg.sv
package exec_pkg;

    ////////////////////////////////////////
    // Memory access.
    ////////////////////////////////////////

    // Same encoding as funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {
        MEM_ACC_8  = 2'b00,
        MEM_ACC_16 = 2'b01,
        MEM_ACC_32 = 2'b10
    } mem_width_t;

    ////////////////////////////////////////
    // Execute sequencing.
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        STEP_ISSUE = 2'b00,
        STEP_WAIT  = 2'b01,
        STEP_DONE  = 2'b10
    } exec_step_t;

    ////////////////////////////////////////
    // Data memory.
    ////////////////////////////////////////

    localparam int RAM_BYTES     = 256;
    localparam int RAM_WAIT      = 2;  // Cycles from first req to ready.
    localparam int RAM_ADDR_BITS = $clog2(RAM_BYTES);
    localparam int RAM_CNT_BITS  = $clog2(RAM_WAIT + 1);

endpackage

// File: rtl/exec_top.sv
`timescale 1ns/1ps

module exec_top
    import rv_isa_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic [OP_BITS-1:0] op,
    input  logic [F7_BITS-1:0] funct7,
    input  logic [F3_BITS-1:0] funct3,
    input  logic [XLEN-1:0]    pc_in,
    input  logic [XLEN-1:0]    rs1,
    input  logic [XLEN-1:0]    rs2,
    input  logic [XLEN-1:0]    imm,
    output logic [XLEN-1:0]    pc_out,
    output logic [XLEN-1:0]    val_out,
    output logic               flush_pipeline,
    output logic               ready
);

    mem_if mem_bus ();

    exec_unit exec_unit_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .op             (op),
        .funct7         (funct7),
        .funct3         (funct3),
        .pc_in          (pc_in),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .mem            (mem_bus.master),
        .pc_out         (pc_out),
        .val_out        (val_out),
        .flush_pipeline (flush_pipeline),
        .ready          (ready)
    );

    data_ram data_ram_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem_bus.slave)
    );

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic [OP_BITS-1:0] op,
    input  logic [F7_BITS-1:0] funct7,
    input  logic [F3_BITS-1:0] funct3,
    input  logic [XLEN-1:0]    pc_in,
    input  logic [XLEN-1:0]    rs1,
    input  logic [XLEN-1:0]    rs2,
    input  logic [XLEN-1:0]    imm,
    mem_if.master              mem,
    output logic [XLEN-1:0]    pc_out,
    output logic [XLEN-1:0]    val_out,
    output logic               flush_pipeline,
    output logic               ready
);

    exec_step_t         step;
    logic               is_mem;
    logic [XLEN-1:0]    alu_in1;
    logic [XLEN-1:0]    alu_in2;
    logic [XLEN-1:0]    alu_out;
    logic [F3_BITS-1:0] alu_funct3;
    logic               alu_modifier;
    logic [XLEN-1:0]    pc_plus4;
    logic [XLEN-1:0]    pc_plus_imm;
    logic [XLEN-1:0]    rs1_plus_imm;
    logic               taken;
    mem_width_t         acc_width;
    logic               ext_bit;
    logic [XLEN-1:0]    load_data;
    logic [XLEN-1:0]    load_val;

    assign is_mem       = (op == OP_LOAD) || (op == OP_STORE);
    assign pc_plus4     = pc_in + XLEN'(4);
    assign pc_plus_imm  = pc_in + imm;
    assign rs1_plus_imm = rs1 + imm;
    assign acc_width    = mem_width_t'(funct3[1:0]);

    alu alu_inst (
        .funct3   (alu_funct3),
        .modifier (alu_modifier),
        .in1      (alu_in1),
        .in2      (alu_in2),
        .out      (alu_out)
    );

    ////////////////////////////////////////
    // Decode and branch resolution.
    ////////////////////////////////////////

    always_comb begin
        alu_in1      = rs1;
        alu_in2      = rs2;
        alu_funct3   = F3_ADD;
        alu_modifier = 1'b0;
        taken        = 1'b0;
        pc_out       = pc_plus4;
        val_out      = alu_out;
        case (op)
            OP_LUI: begin
                alu_in1 = imm;
                alu_in2 = '0;
            end
            OP_AUIPC: begin
                alu_in1 = pc_in;
                alu_in2 = imm;
            end
            OP_JAL, OP_JALR: begin
                alu_in1 = pc_in;            // Link value.
                alu_in2 = XLEN'(4);
                taken   = 1'b1;
                if (op == OP_JAL)
                    pc_out = pc_plus_imm;
                else
                    pc_out = {rs1_plus_imm[XLEN-1:1], 1'b0};
            end
            OP_INTEGER_IMM: begin
                alu_in2    = imm;
                alu_funct3 = funct3;
                // Only SRAI uses the modifier in the immediate form.
                alu_modifier = (funct3 == F3_SR) && funct7[5];
            end
            OP_INTEGER: begin
                alu_funct3   = funct3;
                alu_modifier = funct7[5];
            end
            OP_LOAD, OP_STORE: begin
                alu_in2 = imm;              // Effective address.
                if (op == OP_LOAD)
                    val_out = load_val;
            end
            OP_BRANCH: begin
                case (funct3)
                    F3_EQ: begin
                        alu_modifier = 1'b1;
                        taken        = (alu_out == '0);
                    end
                    F3_NE: begin
                        alu_modifier = 1'b1;
                        taken        = (alu_out != '0);
                    end
                    F3_LT: begin
                        alu_funct3 = F3_SLT;
                        taken      = alu_out[0];
                    end
                    F3_GE: begin
                        alu_funct3 = F3_SLT;
                        taken      = !alu_out[0];
                    end
                    F3_LTU: begin
                        alu_funct3 = F3_SLTU;
                        taken      = alu_out[0];
                    end
                    F3_GEU: begin
                        alu_funct3 = F3_SLTU;
                        taken      = !alu_out[0];
                    end
                    default: taken = 1'b0;
                endcase
                if (taken)
                    pc_out = pc_plus_imm;
            end
            default: ;
        endcase
    end

    assign flush_pipeline = en && taken;

    ////////////////////////////////////////
    // Memory request and load extension.
    ////////////////////////////////////////

    always_comb begin
        mem.req   = en && is_mem && (step != STEP_DONE);
        mem.we    = (op == OP_STORE);
        mem.addr  = alu_out;
        mem.wdata = rs2;
        mem.width = acc_width;
    end

    always_ff @(posedge clk) begin
        if (step == STEP_WAIT && mem.ready)
            load_data <= mem.rdata;
    end

    assign ext_bit = !funct3[2]; // Set for signed loads.

    always_comb begin
        case (acc_width)
            MEM_ACC_8:  load_val = {{(XLEN-8){ext_bit & load_data[7]}}, load_data[7:0]};
            MEM_ACC_16: load_val = {{(XLEN-16){ext_bit & load_data[15]}}, load_data[15:0]};
            default:    load_val = load_data;
        endcase
    end

    ////////////////////////////////////////
    // Step sequencing.
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step  <= STEP_ISSUE;
            ready <= 1'b0;
        end else if (!en) begin
            step  <= STEP_ISSUE;
            ready <= 1'b0;
        end else begin
            ready <= (step == STEP_DONE);
            case (step)
                STEP_ISSUE: step <= is_mem ? STEP_WAIT : STEP_DONE;
                STEP_WAIT: begin
                    if (mem.ready)
                        step <= STEP_DONE;
                end
                default: ; // DONE holds until en drops.
            endcase
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (step == STEP_WAIT && mem.req && !mem.ready)
            |=> (step != STEP_WAIT) || $stable(mem.addr));

    a_no_mem_flush: assert property (@(posedge clk) disable iff (!rst_n)
        is_mem |-> !flush_pipeline);

    a_ready_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready) |-> $past(en));

endmodule

// File: rtl/mem_if.sv
`timescale 1ns/1ps

interface mem_if
    import rv_isa_pkg::*, exec_pkg::*;
();

    // Request held steady while req is high.
    logic            req;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    mem_width_t      width;

    // Response.
    logic [XLEN-1:0] rdata;
    logic            ready; // One-cycle pulse.

    modport master (
        output req, we, addr, wdata, width,
        input  rdata, ready
    );

    modport slave (
        input  req, we, addr, wdata, width,
        output rdata, ready
    );

endinterface

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    ////////////////////////////////////////
    // Widths.
    ////////////////////////////////////////

    localparam int XLEN    = 32;
    localparam int OP_BITS = 7;
    localparam int F3_BITS = 3;
    localparam int F7_BITS = 7;

    ////////////////////////////////////////
    // Opcodes.
    ////////////////////////////////////////

    localparam logic [OP_BITS-1:0] OP_LUI         = 7'b0110111;
    localparam logic [OP_BITS-1:0] OP_AUIPC       = 7'b0010111;
    localparam logic [OP_BITS-1:0] OP_JAL         = 7'b1101111;
    localparam logic [OP_BITS-1:0] OP_JALR        = 7'b1100111;
    localparam logic [OP_BITS-1:0] OP_LOAD        = 7'b0000011;
    localparam logic [OP_BITS-1:0] OP_STORE       = 7'b0100011;
    localparam logic [OP_BITS-1:0] OP_BRANCH      = 7'b1100011;
    localparam logic [OP_BITS-1:0] OP_INTEGER_IMM = 7'b0010011;
    localparam logic [OP_BITS-1:0] OP_INTEGER     = 7'b0110011;

    // ALU funct3.
    localparam logic [F3_BITS-1:0] F3_ADD  = 3'b000;
    localparam logic [F3_BITS-1:0] F3_SLL  = 3'b001;
    localparam logic [F3_BITS-1:0] F3_SLT  = 3'b010;
    localparam logic [F3_BITS-1:0] F3_SLTU = 3'b011;
    localparam logic [F3_BITS-1:0] F3_XOR  = 3'b100;
    localparam logic [F3_BITS-1:0] F3_SR   = 3'b101; // SRL or SRA.
    localparam logic [F3_BITS-1:0] F3_OR   = 3'b110;
    localparam logic [F3_BITS-1:0] F3_AND  = 3'b111;

    // Branch funct3.
    localparam logic [F3_BITS-1:0] F3_EQ  = 3'b000;
    localparam logic [F3_BITS-1:0] F3_NE  = 3'b001;
    localparam logic [F3_BITS-1:0] F3_LT  = 3'b100;
    localparam logic [F3_BITS-1:0] F3_GE  = 3'b101;
    localparam logic [F3_BITS-1:0] F3_LTU = 3'b110;
    localparam logic [F3_BITS-1:0] F3_GEU = 3'b111;

endpackage
